//--- Bender.yml
package:
  name: wbFpAdder

sources:
  - source/fpPkg.sv
  - source/wbRegPkg.sv
  - source/fpAlign.sv
  - source/mantissaAdder.sv
  - source/fpNormalize.sv
  - source/fpAddPipe.sv
  - source/wbFpAdder.sv
  - target: test
    files:
      - test/tbWbFpAdder.sv

//--- build.f
source/fpPkg.sv
source/wbRegPkg.sv
source/fpAlign.sv
source/mantissaAdder.sv
source/fpNormalize.sv
source/fpAddPipe.sv
source/wbFpAdder.sv
test/tbWbFpAdder.sv

//--- source/fpAddPipe.sv
`default_nettype none
`timescale 1ns/10ps

module fpAddPipe #(
	parameter int pipeStages = 3
) (
	input logic clk,
	input logic arstN,
	input logic inValid,
	input logic [fpPkg::fpWidth-1:0] opA,
	input logic [fpPkg::fpWidth-1:0] opB,
	input fpPkg::fpOp op,
	output logic outValid,
	output logic [fpPkg::fpWidth-1:0] result,
	output logic overflow,
	output logic zero
);
	import fpPkg::*;

	logic [pipeStages-1:0] stageValid;

	logic [expWidth-1:0] alExp;
	logic alSign;
	logic [alignWidth-1:0] alBig;
	logic [alignWidth-1:0] alSmall;
	logic alEffSub;

	logic [expWidth-1:0] s1Exp;
	logic s1Sign;
	logic [alignWidth-1:0] s1Big;
	logic [alignWidth-1:0] s1Small;
	logic s1EffSub;

	logic [sumWidth-1:0] addSum;
	logic [sumWidth-1:0] s2Sum;
	logic [expWidth-1:0] s2Exp;
	logic s2Sign;

	logic [fpWidth-1:0] nmResult;
	logic nmOverflow;
	logic nmZero;

	fpAlign u_fpAlign (
		.opA(opA),
		.opB(opB),
		.op(op),
		.bigExp(alExp),
		.sign(alSign),
		.bigMant(alBig),
		.smallMant(alSmall),
		.effSub(alEffSub)
	);

	mantissaAdder u_mantissaAdder (
		.a(s1Big),
		.b(s1Small),
		.sub(s1EffSub),
		.sum(addSum)
	);

	fpNormalize u_fpNormalize (
		.sum(s2Sum),
		.exp(s2Exp),
		.sign(s2Sign),
		.result(nmResult),
		.overflow(nmOverflow),
		.zero(nmZero)
	);

	// No stall, every stage moves each cycle.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			stageValid <= '0;
			s1Exp <= '0;
			s1Sign <= 1'b0;
			s1Big <= '0;
			s1Small <= '0;
			s1EffSub <= 1'b0;
			s2Sum <= '0;
			s2Exp <= '0;
			s2Sign <= 1'b0;
			result <= '0;
			overflow <= 1'b0;
			zero <= 1'b0;
		end else begin
			stageValid <= {stageValid[pipeStages-2:0], inValid};
			s1Exp <= alExp;
			s1Sign <= alSign;
			s1Big <= alBig;
			s1Small <= alSmall;
			s1EffSub <= alEffSub;
			s2Sum <= addSum;
			s2Exp <= s1Exp;
			s2Sign <= s1Sign;
			result <= nmResult;
			overflow <= nmOverflow;
			zero <= nmZero;
		end
	end

	assign outValid = stageValid[pipeStages-1];

endmodule

`default_nettype wire

//--- source/fpAlign.sv
`default_nettype none
`timescale 1ns/10ps

module fpAlign (
	input logic [fpPkg::fpWidth-1:0] opA,
	input logic [fpPkg::fpWidth-1:0] opB,
	input fpPkg::fpOp op,
	output logic [fpPkg::expWidth-1:0] bigExp,
	output logic sign,
	output logic [fpPkg::alignWidth-1:0] bigMant,
	output logic [fpPkg::alignWidth-1:0] smallMant,
	output logic effSub
);
	import fpPkg::*;

	logic signA;
	logic signB;
	logic [expWidth-1:0] expA;
	logic [expWidth-1:0] expB;
	logic [expWidth-1:0] smallExp;
	logic [expWidth-1:0] expDiff;
	logic [fracWidth:0] mantA;
	logic [fracWidth:0] mantB;
	logic [fracWidth:0] bigM;
	logic [fracWidth:0] smallM;
	logic aIsBig;
	logic [alignWidth-1:0] smallExt;
	logic [alignWidth-1:0] shifted;
	logic [alignWidth-1:0] lostMask;
	logic sticky;

	assign signA = opA[fpWidth-1];
	// Subtraction is addition with B negated.
	assign signB = opB[fpWidth-1] ^ (op == opSub);
	assign expA = opA[fpWidth-2 -: expWidth];
	assign expB = opB[fpWidth-2 -: expWidth];

	// Zero exponent means zero or denormal, both taken as zero.
	assign mantA = (expA != '0) ? {1'b1, opA[fracWidth-1:0]} : '0;
	assign mantB = (expB != '0) ? {1'b1, opB[fracWidth-1:0]} : '0;

	assign aIsBig = {expA, mantA} >= {expB, mantB};

	assign bigExp = aIsBig ? expA : expB;
	assign smallExp = aIsBig ? expB : expA;
	assign bigM = aIsBig ? mantA : mantB;
	assign smallM = aIsBig ? mantB : mantA;
	assign sign = aIsBig ? signA : signB;
	assign effSub = signA ^ signB;

	assign expDiff = bigExp - smallExp;
	assign bigMant = {bigM, 3'b000};
	assign smallExt = {smallM, 3'b000};

	// Bits that fall off the bottom of the shifter.
	assign lostMask = ~({alignWidth{1'b1}} << expDiff);

	always_comb begin
		if (expDiff >= alignWidth) begin
			shifted = '0;
			sticky = |smallExt;
		end else begin
			shifted = smallExt >> expDiff;
			sticky = |(smallExt & lostMask);
		end
	end

	assign smallMant = {shifted[alignWidth-1:1], shifted[0] | sticky};

endmodule

`default_nettype wire

//--- source/fpNormalize.sv
`default_nettype none
`timescale 1ns/10ps

module fpNormalize (
	input logic [fpPkg::sumWidth-1:0] sum,
	input logic [fpPkg::expWidth-1:0] exp,
	input logic sign,
	output logic [fpPkg::fpWidth-1:0] result,
	output logic overflow,
	output logic zero
);
	import fpPkg::*;

	localparam int lzWidth = $clog2(alignWidth);
	// Largest finite biased exponent.
	localparam int expMax = 2 * expBias;

	function automatic logic [lzWidth-1:0] leadZeros(input logic [alignWidth-1:0] value);
		logic [lzWidth-1:0] count;
		logic found;
		count = '0;
		found = 1'b0;
		for (int i = alignWidth - 1; i >= 0; i--) begin
			if (!found && value[i]) begin
				found = 1'b1;
				count = lzWidth'(alignWidth - 1 - i);
			end
		end
		return count;
	endfunction

	logic carryOut;
	logic [lzWidth-1:0] lz;
	logic signed [expWidth+1:0] expIn;
	logic signed [expWidth+1:0] lzWide;
	logic signed [expWidth+1:0] normExp;
	logic signed [expWidth+1:0] rndExp;
	logic [alignWidth-1:0] normMant;
	logic roundUp;
	logic [fracWidth+1:0] rndMant;
	logic [fracWidth-1:0] fracOut;

	assign carryOut = sum[sumWidth-1];
	assign lz = leadZeros(sum[alignWidth-1:0]);
	assign expIn = {2'b00, exp};
	assign lzWide = {{(expWidth + 2 - lzWidth){1'b0}}, lz};

	always_comb begin
		if (carryOut) begin
			// Keep the dropped bit in sticky.
			normMant = {sum[sumWidth-1:2], sum[1] | sum[0]};
			normExp = expIn + 10'sd1;
		end else begin
			normMant = sum[alignWidth-1:0] << lz;
			normExp = expIn - lzWide;
		end
	end

	// Nearest-even from guard, round and sticky.
	assign roundUp = normMant[2] & (normMant[1] | normMant[0] | normMant[3]);
	assign rndMant = {1'b0, normMant[alignWidth-1:3]} + {{(fracWidth + 1){1'b0}}, roundUp};

	// A rounding carry leaves 1.000..., one more exponent step.
	assign rndExp = normExp + {{(expWidth + 1){1'b0}}, rndMant[fracWidth+1]};
	assign fracOut = rndMant[fracWidth-1:0];

	always_comb begin
		overflow = 1'b0;
		zero = 1'b0;
		if (sum == '0 || normExp <= 0) begin
			// Underflow flushes to zero as well.
			result = '0;
			zero = 1'b1;
		end else if (rndExp > expMax) begin
			result = {sign, {expWidth{1'b1}}, {fracWidth{1'b0}}};
			overflow = 1'b1;
		end else begin
			result = {sign, rndExp[expWidth-1:0], fracOut};
		end
	end

endmodule

`default_nettype wire

//--- source/fpPkg.sv
`default_nettype none

package fpPkg;

	// Binary32 field layout.
	localparam int fpWidth = 32;
	localparam int expWidth = 8;
	localparam int fracWidth = 23;

	localparam logic [expWidth-1:0] expBias = 8'd127;

	// Hidden bit, fraction, guard, round and sticky.
	localparam int alignWidth = 27;

	// Aligned width plus the adder carry-out.
	localparam int sumWidth = 28;

	typedef enum logic {
		opAdd = 1'b0,
		opSub = 1'b1
	} fpOp;

endpackage

`default_nettype wire

//--- source/mantissaAdder.sv
`default_nettype none
`timescale 1ns/10ps

module mantissaAdder (
	input logic [fpPkg::alignWidth-1:0] a,
	input logic [fpPkg::alignWidth-1:0] b,
	input logic sub,
	output logic [fpPkg::sumWidth-1:0] sum
);
	import fpPkg::*;

	logic [alignWidth-1:0] bEff;
	logic [alignWidth:0] carry;

	// Two's complement of b when subtracting.
	assign bEff = b ^ {alignWidth{sub}};
	assign carry[0] = sub;

	for (genvar i = 0; i < alignWidth; i++) begin : gCell
		assign sum[i] = a[i] ^ bEff[i] ^ carry[i];
		assign carry[i+1] = (a[i] & bEff[i]) | (carry[i] & (a[i] ^ bEff[i]));
	end

	// a >= b on subtract, so the carry there is only the end-around bit
	assign sum[sumWidth-1] = carry[alignWidth] & ~sub;

endmodule

`default_nettype wire

//--- source/wbFpAdder.sv
`default_nettype none
`timescale 1ns/10ps

module wbFpAdder #(
	parameter int pipeStages = 3
) (
	input logic clk,
	input logic arstN,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [wbRegPkg::wbAddrWidth-1:0] adr,
	input logic [wbRegPkg::wbDataWidth/8-1:0] sel,
	input logic [wbRegPkg::wbDataWidth-1:0] datIn,
	output logic [wbRegPkg::wbDataWidth-1:0] datOut,
	output logic ack
);
	import fpPkg::*;
	import wbRegPkg::*;

	wbState state;
	logic [2:0] wordIdx;
	logic accept;
	logic startReq;
	logic [wbDataWidth-1:0] readData;

	logic [fpWidth-1:0] opAReg;
	logic [fpWidth-1:0] opBReg;
	fpOp opReg;
	logic [fpWidth-1:0] resultReg;
	logic ovfFlag;
	logic zeroFlag;
	logic busy;
	logic done;
	logic launch;

	logic pipeValid;
	logic [fpWidth-1:0] pipeResult;
	logic pipeOverflow;
	logic pipeZero;

	// Full-word access only, sel is not decoded.
	assign wordIdx = adr[wbAddrWidth-1:2];
	assign accept = (state == wbIdle) && cyc && stb;
	assign startReq = accept && we && (wordIdx == regCtrl) && datIn[ctrlStartBit] && !busy;
	assign ack = (state == wbAck);

	always_comb begin
		readData = '0;
		case (wordIdx)
			regOpA: readData = opAReg;
			regOpB: readData = opBReg;
			regCtrl: readData[ctrlOpBit] = opReg;
			regStatus: begin
				readData[statBusyBit] = busy;
				readData[statDoneBit] = done;
				readData[statOverflowBit] = ovfFlag;
				readData[statZeroBit] = zeroFlag;
			end
			regResult: readData = resultReg;
			default: readData = '0;
		endcase
	end

	// One ack cycle per access, never stalls.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= wbIdle;
			datOut <= '0;
		end else begin
			case (state)
				wbIdle: begin
					if (accept) begin
						state <= wbAck;
						if (!we) begin
							datOut <= readData;
						end
					end
				end
				default: state <= wbIdle;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			opAReg <= '0;
			opBReg <= '0;
			opReg <= opAdd;
			resultReg <= '0;
			ovfFlag <= 1'b0;
			zeroFlag <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			launch <= 1'b0;
		end else begin
			launch <= startReq;
			if (accept && we && wordIdx == regOpA) begin
				opAReg <= datIn;
			end
			if (accept && we && wordIdx == regOpB) begin
				opBReg <= datIn;
			end
			if (startReq) begin
				opReg <= fpOp'(datIn[ctrlOpBit]);
				busy <= 1'b1;
				done <= 1'b0;
			end
			// Result lands one cycle after the last stage.
			if (pipeValid) begin
				resultReg <= pipeResult;
				ovfFlag <= pipeOverflow;
				zeroFlag <= pipeZero;
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	fpAddPipe #(
		.pipeStages(pipeStages)
	) u_fpAddPipe (
		.clk(clk),
		.arstN(arstN),
		.inValid(launch),
		.opA(opAReg),
		.opB(opBReg),
		.op(opReg),
		.outValid(pipeValid),
		.result(pipeResult),
		.overflow(pipeOverflow),
		.zero(pipeZero)
	);

endmodule

`default_nettype wire

//--- source/wbRegPkg.sv
`default_nettype none

package wbRegPkg;

	localparam int wbAddrWidth = 5;
	localparam int wbDataWidth = 32;

	// Word indices, taken from adr[4:2].
	localparam logic [2:0] regOpA = 3'd0;
	localparam logic [2:0] regOpB = 3'd1;
	localparam logic [2:0] regCtrl = 3'd2;
	localparam logic [2:0] regStatus = 3'd3;
	localparam logic [2:0] regResult = 3'd4;

	// Control word bits.
	localparam int ctrlStartBit = 0;
	localparam int ctrlOpBit = 1;

	// Status word bits.
	localparam int statBusyBit = 0;
	localparam int statDoneBit = 1;
	localparam int statOverflowBit = 2;
	localparam int statZeroBit = 3;

	typedef enum logic {
		wbIdle = 1'b0,
		wbAck = 1'b1
	} wbState;

endpackage

`default_nettype wire

//--- test/tbWbFpAdder.sv
`default_nettype none
`timescale 1ns/10ps

module tbWbFpAdder;
	import fpPkg::*;
	import wbRegPkg::*;

	localparam int pipeStages = 3;
	localparam int randomOps = 200;
	localparam int directedOps = 20;
	// Every operation takes well under 30 cycles, the rest covers the bus checks.
	localparam int cycleLimit = (directedOps + 2 * randomOps) * 30 + 200;
	localparam int ackLimit = 8;
	localparam int pollLimit = 20;

	logic clk;
	logic arstN;
	logic cyc;
	logic stb;
	logic we;
	logic [wbAddrWidth-1:0] adr;
	logic [wbDataWidth/8-1:0] sel;
	logic [wbDataWidth-1:0] datIn;
	logic [wbDataWidth-1:0] datOut;
	logic ack;

	logic [31:0] lcgState = 32'h913d;
	int cycleCount = 0;

	wbFpAdder #(
		.pipeStages(pipeStages)
	) u_wbFpAdder (
		.clk(clk),
		.arstN(arstN),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.sel(sel),
		.datIn(datIn),
		.datOut(datOut),
		.ack(ack)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			abortRun("timeout, the tests did not finish within the cycle limit");
		end
	end

	task automatic checkWord(input string name, input logic [wbDataWidth-1:0] got,
			input logic [wbDataWidth-1:0] expected);
		if (got !== expected) begin
			abortRun($sformatf("error: %s got 0x%h, expected 0x%h", name, got, expected));
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			abortRun($sformatf("error: %s got 0x%h, expected 0x%h", name, got, expected));
		end
	endtask

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic waitAck(input string what);
		int waited;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > ackLimit) begin
				abortRun({"no ack on ", what});
			end
		end while (!ack);
	endtask

	// Master drops its strobe after ack; the slave must not ack again.
	task automatic endAccess();
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
		@(negedge clk);
		if (ack) begin
			abortRun("ack stayed high for more than one cycle");
		end
	endtask

	task automatic wbWrite(input logic [2:0] wordIdx, input logic [wbDataWidth-1:0] data);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= 1'b1;
		adr <= {wordIdx, 2'b00};
		datIn <= data;
		sel <= '1;
		waitAck("write");
		endAccess();
	endtask

	task automatic wbRead(input logic [2:0] wordIdx, output logic [wbDataWidth-1:0] data);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= 1'b0;
		adr <= {wordIdx, 2'b00};
		sel <= '1;
		waitAck("read");
		data = datOut;
		endAccess();
	endtask

	function automatic logic [wbDataWidth-1:0] ctrlWord(input fpOp op);
		logic [wbDataWidth-1:0] value;
		value = '0;
		value[ctrlStartBit] = 1'b1;
		value[ctrlOpBit] = op;
		return value;
	endfunction

	// Binary32 to double, zero and denormal exponents read as zero.
	function automatic real toReal(input logic [31:0] bits);
		logic [63:0] dbl;
		if (bits[30:23] == 8'd0) begin
			return 0.0;
		end
		dbl = {bits[31], {3'b000, bits[30:23]} + 11'd896, bits[22:0], 29'd0};
		return $bitstoreal(dbl);
	endfunction

	// Nonzero normal double to binary32, nearest-even, overflow to infinity.
	function automatic logic [31:0] roundToSingle(input real value);
		logic [63:0] dbl;
		logic [52:0] mant;
		logic [24:0] kept;
		logic roundUp;
		int expOut;
		dbl = $realtobits(value);
		mant = {1'b1, dbl[51:0]};
		roundUp = mant[28] & ((|mant[27:0]) | mant[29]);
		kept = {1'b0, mant[52:29]} + {24'd0, roundUp};
		expOut = int'(dbl[62:52]) - 896;
		if (kept[24]) begin
			kept = kept >> 1;
			expOut++;
		end
		if (expOut >= 255) begin
			return {dbl[63], 8'hff, 23'd0};
		end
		return {dbl[63], expOut[7:0], kept[22:0]};
	endfunction

	task automatic modelOp(input logic [31:0] a, input logic [31:0] b, input fpOp op,
			output logic [31:0] expResult, output logic expOverflow, output logic expZero);
		logic [31:0] bNeg;
		int diff;
		real exact;
		real magnitude;
		bNeg = b ^ {op == opSub, 31'd0};
		diff = int'(a[30:23]) - int'(b[30:23]);
		if (diff < 0) begin
			diff = -diff;
		end
		expOverflow = 1'b0;
		expZero = 1'b0;
		if (diff > 29) begin
			// Smaller operand is far below half an ulp of the larger.
			expResult = (a[30:0] >= b[30:0]) ? a : bNeg;
		end else begin
			// Exact in double for differences up to 29.
			exact = toReal(a) + toReal(bNeg);
			magnitude = (exact < 0.0) ? -exact : exact;
			if (magnitude < toReal(32'h0080_0000)) begin
				expResult = '0;
				expZero = 1'b1;
			end else begin
				expResult = roundToSingle(exact);
				expOverflow = (expResult[30:23] == 8'hff);
			end
		end
	endtask

	task automatic waitDone(output logic [wbDataWidth-1:0] status);
		int polls;
		polls = 0;
		do begin
			wbRead(regStatus, status);
			polls++;
			if (polls > pollLimit) begin
				abortRun("status.done never went high");
			end
		end while (!status[statDoneBit]);
	endtask

	task automatic runOp(input logic [31:0] a, input logic [31:0] b, input fpOp op,
			output logic [31:0] result, output logic [wbDataWidth-1:0] status);
		wbWrite(regOpA, a);
		wbWrite(regOpB, b);
		wbWrite(regCtrl, ctrlWord(op));
		waitDone(status);
		wbRead(regResult, result);
	endtask

	task automatic checkOp(input logic [31:0] a, input logic [31:0] b, input fpOp op);
		logic [31:0] got;
		logic [wbDataWidth-1:0] status;
		logic [31:0] expResult;
		logic expOverflow;
		logic expZero;
		string label;
		label = $sformatf("%h %s %h", a, (op == opSub) ? "-" : "+", b);
		runOp(a, b, op, got, status);
		modelOp(a, b, op, expResult, expOverflow, expZero);
		checkWord({"result of ", label}, got, expResult);
		checkFlag({"status.overflow of ", label}, status[statOverflowBit], expOverflow);
		checkFlag({"status.zero of ", label}, status[statZeroBit], expZero);
		checkFlag({"status.busy of ", label}, status[statBusyBit], 1'b0);
	endtask

	task automatic randomPair(output logic [31:0] a, output logic [31:0] b);
		int expA;
		int expB;
		int diff;
		int swap;
		logic [31:0] r;
		expA = 1 + int'((nextRandom() >> 8) % 254);
		diff = int'((nextRandom() >> 8) % 30);
		expB = (expA - diff >= 1) ? expA - diff : expA + diff;
		r = nextRandom();
		if (r[20]) begin
			swap = expA;
			expA = expB;
			expB = swap;
		end
		r = nextRandom();
		a = {r[31], expA[7:0], r[30:8]};
		r = nextRandom();
		b = {r[31], expB[7:0], r[30:8]};
	endtask

	task automatic checkReset();
		logic [wbDataWidth-1:0] value;
		wbRead(regStatus, value);
		checkWord("status after reset", value, '0);
		wbRead(regResult, value);
		checkWord("result after reset", value, '0);
		for (int idx = 5; idx < 8; idx++) begin
			wbRead(3'(idx), value);
			checkWord($sformatf("unmapped word %0d", idx), value, '0);
		end
		wbWrite(regOpA, 32'h3fc0_0000);
		wbWrite(regOpB, 32'hc049_0fdb);
		wbRead(regOpA, value);
		checkWord("opA readback", value, 32'h3fc0_0000);
		wbRead(regOpB, value);
		checkWord("opB readback", value, 32'hc049_0fdb);
		// Status and result are read only.
		wbWrite(regStatus, '1);
		wbWrite(regResult, 32'h1234_5678);
		wbRead(regStatus, value);
		checkWord("status after write", value, '0);
		wbRead(regResult, value);
		checkWord("result after write", value, '0);
	endtask

	task automatic checkAddition();
		logic [31:0] a;
		logic [31:0] b;
		checkOp(32'h3f80_0000, 32'h3f80_0000, opAdd);
		checkOp(32'h3fc0_0000, 32'h4010_0000, opAdd);
		// 1.75 + 1.5 carries out of the mantissa.
		checkOp(32'h3fe0_0000, 32'h3fc0_0000, opAdd);
		// Exact halfway ties, one rounds down and one up to even.
		checkOp(32'h3f80_0000, 32'h3380_0000, opAdd);
		checkOp(32'h3f80_0001, 32'h3380_0000, opAdd);
		for (int i = 0; i < randomOps; i++) begin
			randomPair(a, b);
			checkOp(a, b, opAdd);
		end
	endtask

	task automatic checkSubtraction();
		logic [31:0] a;
		logic [31:0] b;
		checkOp(32'h4049_0fdb, 32'h4049_0fdb, opSub);
		checkOp(32'h4040_0000, 32'h3f80_0000, opSub);
		checkOp(32'h3f80_0000, 32'h4040_0000, opSub);
		// Near-equal pairs, the result shifts left by 23 and 24.
		checkOp(32'h3f80_0001, 32'h3f80_0000, opSub);
		checkOp(32'h3f80_0000, 32'h3f7f_ffff, opSub);
		for (int i = 0; i < randomOps; i++) begin
			randomPair(a, b);
			checkOp(a, b, opSub);
		end
	endtask

	task automatic checkLargeDiff();
		checkOp(32'h5000_0000, 32'hbf80_0000, opAdd);
		checkOp(32'h5012_3456, 32'hb380_0000, opAdd);
		checkOp(32'h3f80_0001, 32'h6000_0000, opSub);
		checkOp(32'hc700_0000, 32'h2a00_0000, opSub);
		checkOp(32'h7f7f_ffff, 32'h3f80_0000, opAdd);
	endtask

	task automatic checkOverflow();
		checkOp(32'h7f7f_ffff, 32'h7f7f_ffff, opAdd);
		checkOp(32'hff7f_ffff, 32'hff00_0000, opAdd);
		checkOp(32'h7f7f_ffff, 32'hff7f_ffff, opSub);
		checkOp(32'h7f00_0000, 32'h7f00_0000, opAdd);
	endtask

	task automatic checkBusyStart();
		logic [wbDataWidth-1:0] status;
		logic [31:0] result;
		logic [31:0] value;
		logic [31:0] expResult;
		logic expOverflow;
		logic expZero;
		modelOp(32'h4040_0000, 32'h3f80_0000, opAdd, expResult, expOverflow, expZero);
		wbWrite(regOpA, 32'h4040_0000);
		wbWrite(regOpB, 32'h3f80_0000);
		wbWrite(regCtrl, ctrlWord(opAdd));
		// Arrives while the add is still in the pipeline.
		wbWrite(regCtrl, ctrlWord(opSub));
		waitDone(status);
		wbRead(regResult, result);
		checkWord("result with ignored start", result, expResult);
		wbRead(regCtrl, value);
		checkWord("ctrl after ignored start", value, 32'h0);
		repeat (12) @(posedge clk);
		wbRead(regStatus, status);
		checkFlag("status.busy after ignored start", status[statBusyBit], 1'b0);
		checkFlag("status.done after ignored start", status[statDoneBit], 1'b1);
		wbRead(regResult, result);
		checkWord("late result with ignored start", result, expResult);
	endtask

	initial begin
		arstN = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		sel = '0;
		datIn = '0;
		repeat (2) @(posedge clk);
		arstN <= 1'b1;

		checkReset();
		checkAddition();
		checkSubtraction();
		checkLargeDiff();
		checkOverflow();
		checkBusyStart();

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire
